/* fmul_pkg.sv */
`default_nettype none

package fmul_pkg;

  localparam int word_w    = 32;
  localparam int exp_w     = 8;
  localparam int frac_w    = 23;
  localparam int sig_w     = 24;
  localparam int prod_w    = 48;
  localparam int exp_ext_w = 10;

  typedef logic [word_w-1:0]           fp_word_t;
  typedef logic [exp_w-1:0]            exp_t;
  typedef logic [frac_w-1:0]           frac_t;
  typedef logic [sig_w-1:0]            sig_t;
  typedef logic [prod_w-1:0]           prod_t;
  typedef logic signed [exp_ext_w-1:0] exp_ext_t;

  localparam int   exp_bias = 127;
  localparam exp_t exp_max  = 8'hFF;

  // Canonical quiet NaNs.
  localparam fp_word_t qnan_pos = 32'h7FC0_0000;
  localparam fp_word_t qnan_neg = 32'hFFC0_0000;

  // Exception flag positions.
  localparam int flags_w = 4;
  localparam int flag_nx = 0;
  localparam int flag_uf = 1;
  localparam int flag_of = 2;
  localparam int flag_nv = 3;

  typedef logic [flags_w-1:0] flags_t;

  // Operand class, subnormals count as zero.
  typedef enum logic [1:0] {
    cls_zero,
    cls_normal,
    cls_inf,
    cls_nan
  } op_class_e;

endpackage

`default_nettype wire

/* fmul_special.sv */
`timescale 1ns/10ps
`default_nettype none

module fmul_special import fmul_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     valid_in,
  input  logic     ready_in,
  input  fp_word_t op_a,
  input  fp_word_t op_b,
  output logic     valid_out,
  output logic     ready_out,
  output logic     sign_a,
  output logic     sign_b,
  output exp_t     exp_a,
  output exp_t     exp_b,
  output frac_t    frac_a,
  output frac_t    frac_b,
  output logic     spec_override,
  output fp_word_t spec_result,
  output flags_t   spec_flags
);

  function automatic op_class_e classify(input fp_word_t op);
    exp_t  e;
    frac_t f;
    e = op[frac_w +: exp_w];
    f = op[frac_w-1:0];
    if (e == '0) return cls_zero;
    if (e != exp_max) return cls_normal;
    if (f != '0) return cls_nan;
    return cls_inf;
  endfunction

  op_class_e cls_a;
  op_class_e cls_b;
  logic      sign_r;
  logic      take;
  logic      override_d;
  fp_word_t  result_d;
  flags_t    flags_d;

  assign cls_a     = classify(op_a);
  assign cls_b     = classify(op_b);
  assign sign_r    = op_a[word_w-1] ^ op_b[word_w-1];
  assign ready_out = !valid_out || ready_in;
  assign take      = valid_in && ready_out;

  // Special cases in priority order.
  always_comb begin
    override_d = 1'b1;
    result_d   = '0;
    flags_d    = '0;
    if (cls_a == cls_nan || cls_b == cls_nan) begin
      result_d         = qnan_pos;
      flags_d[flag_nv] = 1'b1;
    end else if ((cls_a == cls_inf && cls_b == cls_zero) ||
                 (cls_a == cls_zero && cls_b == cls_inf)) begin
      result_d         = qnan_neg;
      flags_d[flag_nv] = 1'b1;
    end else if (cls_a == cls_inf || cls_b == cls_inf) begin
      result_d = {sign_r, exp_max, {frac_w{1'b0}}};
    end else if (cls_a == cls_zero || cls_b == cls_zero) begin
      result_d = {sign_r, {(word_w-1){1'b0}}};
    end else begin
      override_d = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_out <= 1'b0;
    end else if (ready_out) begin
      valid_out <= valid_in;
    end
  end

  // Flushed subnormals leave with a zero fraction.
  always_ff @(posedge clk) begin
    if (take) begin
      sign_a        <= op_a[word_w-1];
      sign_b        <= op_b[word_w-1];
      exp_a         <= op_a[frac_w +: exp_w];
      exp_b         <= op_b[frac_w +: exp_w];
      frac_a        <= (cls_a == cls_zero) ? '0 : op_a[frac_w-1:0];
      frac_b        <= (cls_b == cls_zero) ? '0 : op_b[frac_w-1:0];
      spec_override <= override_d;
      spec_result   <= result_d;
      spec_flags    <= flags_d;
    end
  end

  // Two registered normal exponents never travel with an override.
  a_normal_no_override: assert property (@(posedge clk) disable iff (!rst_n)
    valid_out && exp_a != '0 && exp_a != exp_max && exp_b != '0 && exp_b != exp_max
      |-> !spec_override)
    else $error("special stage flagged an override for two normal operands");

endmodule

`default_nettype wire

/* fmul_multiply.sv */
`timescale 1ns/10ps
`default_nettype none

module fmul_multiply import fmul_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     valid_in,
  input  logic     ready_in,
  input  logic     sign_a,
  input  logic     sign_b,
  input  exp_t     exp_a,
  input  exp_t     exp_b,
  input  frac_t    frac_a,
  input  frac_t    frac_b,
  input  logic     spec_override,
  input  fp_word_t spec_result,
  input  flags_t   spec_flags,
  output logic     valid_out,
  output logic     ready_out,
  output logic     sign,
  output exp_ext_t exp_sum,
  output prod_t    prod,
  output logic     spec_override_q,
  output fp_word_t spec_result_q,
  output flags_t   spec_flags_q
);

  sig_t     sig_a;
  sig_t     sig_b;
  exp_ext_t exp_sum_d;
  logic     take;

  // Hidden bit is one for any nonzero exponent.
  assign sig_a = {exp_a != '0, frac_a};
  assign sig_b = {exp_b != '0, frac_b};

  // Signed sum keeps both overflow and values at or below zero visible.
  assign exp_sum_d = exp_ext_t'(exp_a) + exp_ext_t'(exp_b) - exp_ext_t'(exp_bias);

  assign ready_out = !valid_out || ready_in;
  assign take      = valid_in && ready_out;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_out <= 1'b0;
    end else if (ready_out) begin
      valid_out <= valid_in;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      sign            <= sign_a ^ sign_b;
      exp_sum         <= exp_sum_d;
      prod            <= sig_a * sig_b;
      spec_override_q <= spec_override;
      spec_result_q   <= spec_result;
      spec_flags_q    <= spec_flags;
    end
  end

endmodule

`default_nettype wire

/* fmul_round.sv */
`timescale 1ns/10ps
`default_nettype none

module fmul_round import fmul_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     valid_in,
  input  logic     ready_in,
  input  logic     sign,
  input  exp_ext_t exp_sum,
  input  prod_t    prod,
  input  logic     spec_override,
  input  fp_word_t spec_result,
  input  flags_t   spec_flags,
  output logic     valid_out,
  output logic     ready_out,
  output logic     sign_q,
  output exp_t     exp_final,
  output frac_t    frac_final,
  output flags_t   flags,
  output logic     spec_override_q,
  output fp_word_t spec_result_q
);

  prod_t          prod_n;
  exp_ext_t       exp_norm;
  sig_t           kept;
  logic           guard;
  logic           rnd;
  logic           sticky;
  logic           round_up;
  logic [sig_w:0] sig_rnd;
  frac_t          frac_post;
  exp_ext_t       exp_post;
  logic           overflow;
  logic           underflow;
  exp_t           exp_res;
  frac_t          frac_res;
  flags_t         calc_flags;
  logic           take;

  // Align the leading one to bit 47 so one window serves both cases.
  assign prod_n   = prod[prod_w-1] ? prod : prod << 1;
  assign exp_norm = exp_sum + exp_ext_t'(prod[prod_w-1]);

  assign kept   = prod_n[prod_w-1 -: sig_w];
  assign guard  = prod_n[prod_w-sig_w-1];
  assign rnd    = prod_n[prod_w-sig_w-2];
  assign sticky = |prod_n[prod_w-sig_w-3:0];

  // Round to nearest, ties to even.
  assign round_up  = guard && (rnd || sticky || kept[0]);
  assign sig_rnd   = {1'b0, kept} + {{sig_w{1'b0}}, round_up};
  assign frac_post = sig_rnd[sig_w] ? sig_rnd[frac_w:1] : sig_rnd[frac_w-1:0];
  assign exp_post  = exp_norm + exp_ext_t'(sig_rnd[sig_w]);

  assign overflow  = exp_post >= exp_ext_t'(exp_max);
  assign underflow = exp_post <= exp_ext_t'(0);

  always_comb begin
    calc_flags = '0;
    exp_res    = exp_post[exp_w-1:0];
    frac_res   = frac_post;
    if (overflow) begin
      exp_res             = exp_max;
      frac_res            = '0;
      calc_flags[flag_of] = 1'b1;
      calc_flags[flag_nx] = 1'b1;
    end else if (underflow) begin
      exp_res             = '0;
      frac_res            = '0;
      calc_flags[flag_uf] = 1'b1;
      calc_flags[flag_nx] = 1'b1;
    end else begin
      calc_flags[flag_nx] = guard || rnd || sticky;
    end
    // The datapath result is discarded for special operands.
    if (spec_override) calc_flags = '0;
  end

  assign ready_out = !valid_out || ready_in;
  assign take      = valid_in && ready_out;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_out <= 1'b0;
    end else if (ready_out) begin
      valid_out <= valid_in;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      sign_q          <= sign;
      exp_final       <= exp_res;
      frac_final      <= frac_res;
      flags           <= spec_flags | calc_flags;
      spec_override_q <= spec_override;
      spec_result_q   <= spec_result;
    end
  end

  a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
    valid_out && !ready_in |=> valid_out &&
      $stable({sign_q, exp_final, frac_final, flags, spec_override_q, spec_result_q}))
    else $error("round stage changed its output while stalled");

endmodule

`default_nettype wire

/* fmul_pack.sv */
`timescale 1ns/10ps
`default_nettype none

module fmul_pack import fmul_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     valid_in,
  input  logic     ready_in,
  input  logic     sign,
  input  exp_t     exp_final,
  input  frac_t    frac_final,
  input  flags_t   flags,
  input  logic     spec_override,
  input  fp_word_t spec_result,
  output logic     valid_out,
  output logic     ready_out,
  output fp_word_t result,
  output flags_t   flags_out
);

  fp_word_t result_d;
  logic     take;

  assign result_d  = spec_override ? spec_result : {sign, exp_final, frac_final};
  assign ready_out = !valid_out || ready_in;
  assign take      = valid_in && ready_out;

  // Output register, holds the result under back-pressure.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_out <= 1'b0;
      result    <= '0;
      flags_out <= '0;
    end else begin
      if (ready_out) begin
        valid_out <= valid_in;
      end
      if (take) begin
        result    <= result_d;
        flags_out <= flags;
      end
    end
  end

  a_result_stable: assert property (@(posedge clk) disable iff (!rst_n)
    valid_out && !ready_in |=> valid_out && $stable(result) && $stable(flags_out))
    else $error("result changed while the consumer stalled");

endmodule

`default_nettype wire

/* fmul_top.sv */
`timescale 1ns/10ps
`default_nettype none

module fmul_top import fmul_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  fp_word_t op_a,
  input  fp_word_t op_b,
  input  logic     start,
  input  logic     ready_in,
  output logic     valid_out,
  output logic     ready_out,
  output fp_word_t result,
  output flags_t   flags
);

  logic     s1_valid;
  logic     s1_sign_a;
  logic     s1_sign_b;
  exp_t     s1_exp_a;
  exp_t     s1_exp_b;
  frac_t    s1_frac_a;
  frac_t    s1_frac_b;
  logic     s1_override;
  fp_word_t s1_result;
  flags_t   s1_flags;

  logic     s2_valid;
  logic     s2_ready;
  logic     s2_sign;
  exp_ext_t s2_exp_sum;
  prod_t    s2_prod;
  logic     s2_override;
  fp_word_t s2_result;
  flags_t   s2_flags;

  logic     s3_valid;
  logic     s3_ready;
  logic     s3_sign;
  exp_t     s3_exp;
  frac_t    s3_frac;
  flags_t   s3_flags;
  logic     s3_override;
  fp_word_t s3_result;

  logic     s4_ready;

  fmul_special u_special (
    .clk(clk), .rst_n(rst_n),
    .valid_in(start), .ready_in(s2_ready), .op_a(op_a), .op_b(op_b),
    .valid_out(s1_valid), .ready_out(ready_out),
    .sign_a(s1_sign_a), .sign_b(s1_sign_b), .exp_a(s1_exp_a), .exp_b(s1_exp_b),
    .frac_a(s1_frac_a), .frac_b(s1_frac_b),
    .spec_override(s1_override), .spec_result(s1_result), .spec_flags(s1_flags)
  );

  fmul_multiply u_multiply (
    .clk(clk), .rst_n(rst_n),
    .valid_in(s1_valid), .ready_in(s3_ready),
    .sign_a(s1_sign_a), .sign_b(s1_sign_b), .exp_a(s1_exp_a), .exp_b(s1_exp_b),
    .frac_a(s1_frac_a), .frac_b(s1_frac_b),
    .spec_override(s1_override), .spec_result(s1_result), .spec_flags(s1_flags),
    .valid_out(s2_valid), .ready_out(s2_ready),
    .sign(s2_sign), .exp_sum(s2_exp_sum), .prod(s2_prod),
    .spec_override_q(s2_override), .spec_result_q(s2_result), .spec_flags_q(s2_flags)
  );

  fmul_round u_round (
    .clk(clk), .rst_n(rst_n),
    .valid_in(s2_valid), .ready_in(s4_ready),
    .sign(s2_sign), .exp_sum(s2_exp_sum), .prod(s2_prod),
    .spec_override(s2_override), .spec_result(s2_result), .spec_flags(s2_flags),
    .valid_out(s3_valid), .ready_out(s3_ready),
    .sign_q(s3_sign), .exp_final(s3_exp), .frac_final(s3_frac), .flags(s3_flags),
    .spec_override_q(s3_override), .spec_result_q(s3_result)
  );

  fmul_pack u_pack (
    .clk(clk), .rst_n(rst_n),
    .valid_in(s3_valid), .ready_in(ready_in),
    .sign(s3_sign), .exp_final(s3_exp), .frac_final(s3_frac), .flags(s3_flags),
    .spec_override(s3_override), .spec_result(s3_result),
    .valid_out(valid_out), .ready_out(s4_ready),
    .result(result), .flags_out(flags)
  );

endmodule

`default_nettype wire

/* tb_fmul_ref.svh */
`ifndef TB_FMUL_REF_SVH
`define TB_FMUL_REF_SVH
`default_nettype none

// Expected {flags, result} of one single-precision product.
function automatic logic [35:0] fmul_ref(input logic [31:0] a, input logic [31:0] b);
  logic        sign;
  int          ea;
  int          eb;
  int          e;
  logic        a_nan;
  logic        b_nan;
  logic        a_inf;
  logic        b_inf;
  logic [47:0] p;
  logic [24:0] m;
  logic        g;
  logic        r;
  logic        s;
  logic [3:0]  fl;
  sign  = a[31] ^ b[31];
  ea    = a[30:23];
  eb    = b[30:23];
  a_nan = (ea == 255) && (a[22:0] != 0);
  b_nan = (eb == 255) && (b[22:0] != 0);
  a_inf = (ea == 255) && (a[22:0] == 0);
  b_inf = (eb == 255) && (b[22:0] == 0);
  fl    = 4'h0;
  if (a_nan || b_nan) begin
    fl[fmul_pkg::flag_nv] = 1'b1;
    return {fl, fmul_pkg::qnan_pos};
  end
  // Subnormal operands count as zero.
  if ((a_inf && eb == 0) || (b_inf && ea == 0)) begin
    fl[fmul_pkg::flag_nv] = 1'b1;
    return {fl, fmul_pkg::qnan_neg};
  end
  if (a_inf || b_inf) return {fl, sign, 8'hFF, 23'h0};
  if (ea == 0 || eb == 0) return {fl, sign, 31'h0};
  p = {1'b1, a[22:0]} * {1'b1, b[22:0]};
  e = ea + eb - 127;
  if (p[47]) begin
    m = {1'b0, p[47:24]};
    g = p[23];
    r = p[22];
    s = |p[21:0];
    e = e + 1;
  end else begin
    m = {1'b0, p[46:23]};
    g = p[22];
    r = p[21];
    s = |p[20:0];
  end
  // Nearest even, a carry renormalizes.
  if (g && (r || s || m[0])) m = m + 1;
  if (m[24]) begin
    m = m >> 1;
    e = e + 1;
  end
  if (e >= 255) begin
    fl[fmul_pkg::flag_of] = 1'b1;
    fl[fmul_pkg::flag_nx] = 1'b1;
    return {fl, sign, 8'hFF, 23'h0};
  end
  if (e <= 0) begin
    fl[fmul_pkg::flag_uf] = 1'b1;
    fl[fmul_pkg::flag_nx] = 1'b1;
    return {fl, sign, 31'h0};
  end
  fl[fmul_pkg::flag_nx] = g | r | s;
  return {fl, sign, e[7:0], m[22:0]};
endfunction

`default_nettype wire
`endif

/* tb_fmul.sv */
`timescale 1ns/10ps
`include "tb_fmul_ref.svh"
`default_nettype none

module tb_fmul import fmul_pkg::*; ();

  // About 330 operations at up to three cycles each, plus slack.
  localparam int timeout_cycles = 2000;
  localparam int random_ops     = 300;
  localparam int handshake_ops  = 24;
  localparam int drain_limit    = 64;

  logic     clk;
  logic     rst_n;
  fp_word_t op_a;
  fp_word_t op_b;
  logic     start;
  logic     ready_in;
  logic     valid_out;
  logic     ready_out;
  fp_word_t result;
  flags_t   flags;

  integer      seed;
  int          cycles = 0;
  logic [35:0] exp_q[$];

  fmul_top u_dut (
    .clk(clk), .rst_n(rst_n), .op_a(op_a), .op_b(op_b),
    .start(start), .ready_in(ready_in),
    .valid_out(valid_out), .ready_out(ready_out),
    .result(result), .flags(flags)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] want,
                             input logic [31:0] got);
    if (got !== want) begin
      $display("** Error: %s expected %h, got %h", name, want, got);
      $display(">>> FAIL");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  function automatic fp_word_t rand_operand();
    fp_word_t    op;
    logic [31:0] sel;
    op  = $random(seed);
    sel = $random(seed);
    // Most operands sit near the bias so that products stay in range.
    if (sel[1:0] != 2'b00) op[30:23] = 8'd96 + sel[7:2];
    return op;
  endfunction

  // Holds start until the DUT takes the operands.
  task automatic issue(input fp_word_t a, input fp_word_t b);
    op_a  = a;
    op_b  = b;
    start = 1'b1;
    @(posedge clk);
    while (!ready_out) @(posedge clk);
    #1;
  endtask

  task automatic drain();
    start = 1'b0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  // Hand-worked value confirms the reference before the DUT sees the pair.
  task automatic directed_case(input fp_word_t a, input fp_word_t b,
                               input fp_word_t want, input flags_t want_fl);
    logic [35:0] ref_val;
    ref_val = fmul_ref(a, b);
    check_value("reference result", want, ref_val[31:0]);
    check_value("reference flags", want_fl, ref_val[35:32]);
    issue(a, b);
  endtask

  always @(posedge clk) begin : scoreboard
    logic [35:0] want;
    cycles++;
    if (cycles >= timeout_cycles) begin
      $display("Timeout, run did not finish within %0d cycles", timeout_cycles);
      $display(">>> FAIL");
      $fatal(1, "Timeout");
    end else if (rst_n) begin
      // Stage one stalls only with four in flight and the consumer stalled.
      check_value("ready_out", !(exp_q.size() == 4 && !ready_in), ready_out);
      if (valid_out && ready_in && exp_q.size() == 0) begin
        $display("Output transfer with no operation outstanding");
        $display(">>> FAIL");
        $fatal(1, "Unexpected output");
      end else begin
        if (valid_out && ready_in) begin
          want = exp_q.pop_front();
          check_value("result", want[31:0], result);
          check_value("flags", want[35:32], flags);
        end
        if (start && ready_out) exp_q.push_back(fmul_ref(op_a, op_b));
      end
    end
  end

  initial begin : stimulus
    logic [31:0] rnd;
    fp_word_t    a;
    fp_word_t    b;
    int          lat;
    int          sent;
    int          waited;
    logic        accepted;
    seed     = 74917;
    rst_n    = 1'b0;
    start    = 1'b0;
    ready_in = 1'b1;
    op_a     = '0;
    op_b     = '0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_value("valid_out", 0, valid_out);
    check_value("ready_out", 1, ready_out);
    check_value("result", 0, result);
    check_value("flags", 0, flags);

    issue(32'h3FC0_0000, 32'h4000_0000);
    start = 1'b0;
    lat   = 0;
    do begin
      @(posedge clk);
      lat++;
    end while (!valid_out && lat < 10);
    check_value("latency", 4, lat);
    #1;

    directed_case(32'h3FC0_0000, 32'h4000_0000, 32'h4040_0000, 4'h0);
    directed_case(32'hC040_0000, 32'h3F00_0000, 32'hBFC0_0000, 4'h0);
    directed_case(32'h3F80_0001, 32'h3F80_0001, 32'h3F80_0002, 4'h1);
    directed_case(32'h3F80_0001, 32'h3FC0_0000, 32'h3FC0_0002, 4'h1);
    directed_case(32'h3F80_0003, 32'h3FC0_0000, 32'h3FC0_0004, 4'h1);
    directed_case(32'h3FFF_FFFE, 32'h3F80_0001, 32'h4000_0000, 4'h1);
    directed_case(32'h7FC0_0000, 32'h3F80_0000, 32'h7FC0_0000, 4'h8);
    directed_case(32'hFFC0_0001, 32'h4000_0000, 32'h7FC0_0000, 4'h8);
    directed_case(32'h7F80_0000, 32'h0000_0000, 32'hFFC0_0000, 4'h8);
    directed_case(32'h8000_0000, 32'hFF80_0000, 32'hFFC0_0000, 4'h8);
    directed_case(32'hFF80_0000, 32'h4000_0000, 32'hFF80_0000, 4'h0);
    directed_case(32'h8000_0000, 32'h4040_0000, 32'h8000_0000, 4'h0);
    directed_case(32'h0000_0001, 32'hC000_0000, 32'h8000_0000, 4'h0);
    directed_case(32'h7F00_0000, 32'h4000_0000, 32'h7F80_0000, 4'h5);
    directed_case(32'hFF7F_FFFF, 32'h7F7F_FFFF, 32'hFF80_0000, 4'h5);
    directed_case(32'h8080_0000, 32'h3F00_0000, 32'h8000_0000, 4'h3);
    directed_case(32'h0DA2_4260, 32'h0DA2_4260, 32'h0000_0000, 4'h3);
    drain();

    // Fill all four stages behind a stalled consumer.
    ready_in = 1'b0;
    repeat (4) begin
      a = rand_operand();
      b = rand_operand();
      issue(a, b);
    end
    start = 1'b0;
    check_value("ready_out when full", 0, ready_out);
    ready_in = 1'b1;
    drain();

    repeat (random_ops) begin
      a = rand_operand();
      b = rand_operand();
      issue(a, b);
    end
    drain();

    sent = 0;
    while (sent < handshake_ops) begin
      rnd      = $random(seed);
      ready_in = rnd[0];
      if (!start && rnd[1]) begin
        op_a  = rand_operand();
        op_b  = rand_operand();
        start = 1'b1;
      end
      @(posedge clk);
      accepted = start && ready_out;
      #1;
      if (accepted) begin
        sent++;
        start = 1'b0;
      end
    end

    // The last results get a bounded time to come out.
    waited = 0;
    while (exp_q.size() != 0 && waited < drain_limit) begin
      rnd      = $random(seed);
      ready_in = rnd[0];
      @(posedge clk);
      #1;
      waited++;
    end
    ready_in = 1'b1;

    if (exp_q.size() != 0) begin
      $display("Run ended with %0d operations never returned", exp_q.size());
      $display(">>> FAIL");
      $fatal(1, "Outstanding operations");
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+.
fmul_pkg.sv
fmul_special.sv
fmul_multiply.sv
fmul_round.sv
fmul_pack.sv
fmul_top.sv
tb_fmul.sv
